//--- run_sim.sh
#!/bin/sh
# Build and run the u2_control_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_u2_control_core \
   -Mdir obj_dir \
   -f u2_control_core.f > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/Vtb_u2_control_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test OK" sim.log; then
   exit 0
else
   echo "Pass line not found in sim.log"
   exit 1
fi

//--- sim/tb_u2_control_core.sv
/*
 * Testbench for the control core: random settings writes and readbacks,
 * PPS pulses and timed loads, checked against a cycle model
 */
`default_nettype none

module tb_u2_control_core;

   import u2_ctrl_pkg::*;

   localparam int          PERIOD     = 100;
   localparam logic [7:0]  TIME_BASE  = SR_TIME64_DEFAULT;
   localparam logic [31:0] COMPAT_NUM = 32'd3;
   localparam int          N_RESET    = 10;
   localparam int          N_WRITES   = 200;
   localparam int          N_IDLE     = 20;
   localparam int          N_PPS      = 24;
   localparam int          N_CONST    = 30;
   localparam int          N_READS    = 9;
   localparam int          TEST_CYCLES = N_RESET + N_WRITES + 3 * N_IDLE
                                         + 3 * (8 + N_PPS) + N_CONST + 6 + N_READS;
   localparam int          MARGIN     = 50;

   logic        dsp_clk = 1'b0;
   logic        rst_n_i;
   set_bus_t    set_i;
   logic        pps_i, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i;
   logic        rb_stb_i, sim_mode_i;
   rb_word_e    rb_addr_i;
   logic [3:0]  clock_divider_i;
   logic [7:0]  leds_o;
   logic        clock_ready_o, phy_resetn_o, pps_int_o, rb_ack_o;
   logic [1:0]  clk_en_o, clk_sel_o;
   logic        ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic        adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic [31:0] rb_data_o;

   // Model state
   integer      seed = 60268;
   int          errors = 0;
   logic [7:0]  m_clock, m_serdes, m_adc, m_led_sw, m_led_src;
   logic        m_phy, m_wait, m_pps_int, m_ack, m_pps_prev;
   logic        m_rb_seen;
   logic [63:0] m_time, m_pps_time;
   logic [31:0] m_hi, m_lo, m_rb_data;
   int          pps_age;

   u2_control_core #(
      .TIME_BASE  (TIME_BASE),
      .COMPAT_NUM (COMPAT_NUM)
   ) u2_control_core_i (.*);

   always #(PERIOD / 2) dsp_clk = ~dsp_clk;

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic logic [7:0] led_mix();
      logic [7:0] hw;
      logic [7:0] mix;
      hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
      for (int i = 0; i < 8; i++) begin
         mix[i] = m_led_src[i] ? hw[i] : m_led_sw[i];
      end
      return mix;
   endfunction

   // Readback layout by word index
   function automatic logic [31:0] expected_word(input rb_word_e idx);
      case (idx)
         RB_CTRL:    return {7'd0, m_phy, m_adc, m_serdes, m_clock};
         RB_LED:     return {16'd0, m_led_src, m_led_sw};
         RB_TIME_HI: return m_time[63:32];
         RB_TIME_LO: return m_time[31:0];
         RB_PPS_HI:  return m_pps_time[63:32];
         RB_PPS_LO:  return m_pps_time[31:0];
         RB_COMPAT:  return COMPAT_NUM;
         default:    return {sim_mode_i, 27'd0, clock_divider_i};
      endcase
   endfunction

   task automatic compare_value(input string name, input logic [63:0] actual,
                                input logic [63:0] expected);
      if (actual !== expected) begin
         errors = errors + 1;
         $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
      end
   endtask

   task automatic check_outputs();
      compare_value("leds_o", 64'(leds_o), 64'(led_mix()));
      compare_value("clock pins", 64'({clock_ready_o, clk_en_o, clk_sel_o}),
                    64'(m_clock[4:0]));
      compare_value("serdes pins", 64'({ser_enable_o, ser_prbsen_o, ser_loopen_o,
                    ser_rx_en_o}), 64'(m_serdes[3:0]));
      compare_value("adc pins", 64'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
                    64'(m_adc[3:0]));
      compare_value("phy_resetn_o", 64'(phy_resetn_o), 64'(!m_phy));
      compare_value("pps_int_o", 64'(pps_int_o), 64'(m_pps_int));
      compare_value("rb_ack_o", 64'(rb_ack_o), 64'(m_ack));
      // Readback word stays until the next strobe
      if (m_rb_seen) begin
         compare_value("rb_data_o", 64'(rb_data_o), 64'(m_rb_data));
      end
   endtask

   // Apply the edge rules to the model, clock once, then check
   task automatic advance_cycle();
      logic capture;
      logic ctrl_wr;
      if (rb_stb_i) begin
         m_rb_data = expected_word(rb_addr_i);
         m_rb_seen = 1'b1;
      end
      m_ack = rb_stb_i;
      // Capture on the third edge after pps_i is first seen high
      capture = 1'b0;
      if (pps_age >= 0) begin
         pps_age = pps_age + 1;
      end
      if (pps_age == 3) begin
         capture = 1'b1;
         pps_age = -1;
      end
      if (pps_i && !m_pps_prev) begin
         pps_age = 0;
      end
      m_pps_prev = pps_i;
      m_pps_int = capture;
      if (capture) begin
         m_pps_time = m_time;
      end
      ctrl_wr = set_i.stb && (set_i.addr == TIME_BASE + 8'd2);
      if ((ctrl_wr && set_i.data[0]) || (capture && m_wait)) begin
         m_time = {m_hi, m_lo};
      end else begin
         m_time = m_time + 64'd1;
      end
      if (ctrl_wr) begin
         m_wait = !set_i.data[0];
      end else if (capture) begin
         m_wait = 1'b0;
      end
      if (set_i.stb) begin
         case (set_i.addr)
            TIME_BASE:         m_hi = set_i.data;
            TIME_BASE + 8'd1:  m_lo = set_i.data;
            SR_CLOCK:          m_clock = set_i.data[7:0];
            SR_SERDES:         m_serdes = set_i.data[7:0];
            SR_ADC:            m_adc = set_i.data[7:0];
            SR_LED_SW:         m_led_sw = set_i.data[7:0];
            SR_PHY:            m_phy = set_i.data[0];
            SR_LED_SRC:        m_led_src = set_i.data[7:0];
            default:           ;
         endcase
      end
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_outputs();
   endtask

   // Random status, readback and constant inputs without a write
   task automatic drive_misc();
      logic [31:0] r;
      r = rand_word();
      {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} = r[3:0];
      rb_stb_i = r[4];
      rb_addr_i = rb_word_e'(r[7:5]);
      sim_mode_i = r[8];
      clock_divider_i = r[12:9];
      set_i = '0;
   endtask

   task automatic run_idle(input int n);
      repeat (n) begin
         drive_misc();
         advance_cycle();
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      drive_misc();
      set_i = '{stb: 1'b1, addr: addr, data: data};
      advance_cycle();
   endtask

   task automatic read_word(input rb_word_e idx);
      drive_misc();
      rb_stb_i = 1'b1;
      rb_addr_i = idx;
      advance_cycle();
   endtask

   task automatic pps_pulse();
      pps_i = 1'b1;
      run_idle(8);
      pps_i = 1'b0;
      run_idle(N_PPS);
   endtask

   initial begin
      logic [31:0] r;
      rst_n_i = 1'b0;
      pps_i = 1'b0;
      drive_misc();
      rb_stb_i = 1'b0;
      {m_clock, m_serdes, m_adc, m_led_sw} = '0;
      m_led_src = LED_SRC_RESET;
      m_phy = 1'b0;
      m_wait = 1'b0;
      m_pps_int = 1'b0;
      m_ack = 1'b0;
      m_pps_prev = 1'b0;
      m_rb_seen = 1'b0;
      m_time = '0;
      m_pps_time = '0;
      m_hi = '0;
      m_lo = '0;
      m_rb_data = '0;
      pps_age = -1;
      repeat (N_RESET) @(posedge dsp_clk);
      @(negedge dsp_clk);
      rst_n_i = 1'b1;
      check_outputs();

      // Random writes over the bank and unmatched addresses with the LED mix
      repeat (N_WRITES) begin
         drive_misc();
         r = rand_word();
         set_i.stb = r[0];
         set_i.addr = r[15:8] & 8'h0F;
         set_i.data = rand_word();
         advance_cycle();
      end

      // Free-running counter and an immediate load near a carry
      run_idle(N_IDLE);
      write_setting(TIME_BASE, rand_word());
      write_setting(TIME_BASE + 8'd1, 32'hFFFF_FFF8);
      write_setting(TIME_BASE + 8'd2, 32'd1);
      read_word(RB_TIME_HI);
      read_word(RB_TIME_LO);
      run_idle(N_IDLE);

      // PPS capture and a load armed for the next PPS
      pps_pulse();
      read_word(RB_PPS_HI);
      read_word(RB_PPS_LO);
      write_setting(TIME_BASE, rand_word());
      write_setting(TIME_BASE + 8'd1, rand_word());
      write_setting(TIME_BASE + 8'd2, 32'd0);
      run_idle(N_IDLE);
      read_word(RB_TIME_LO);
      pps_pulse();
      read_word(RB_TIME_HI);
      read_word(RB_TIME_LO);
      pps_pulse();

      // Compat and sim words with random inputs
      read_word(RB_COMPAT);
      read_word(RB_SIM);
      run_idle(N_CONST);

      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #((TEST_CYCLES + MARGIN) * PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/u2_control_core_assertions.sv
/*
 * Bound checks on the readback acknowledge and the PPS interrupt pulse
 */
`default_nettype none

module u2_control_core_assertions #(
   parameter bit CHECK_ACK   = 1'b1,
   parameter bit CHECK_PULSE = 1'b1
) (
   input wire dsp_clk,
   input wire rst_n_i,
   input wire stb_i,
   input wire ack_i,
   input wire pulse_i
);

   // Readback strobe and acknowledge
   if (CHECK_ACK) begin : g_ack
      // Every strobe is acknowledged on the next edge
      ack_after_stb: assert property (
         @(posedge dsp_clk) disable iff (!rst_n_i) stb_i |=> ack_i
      ) else $error("readback strobe without acknowledge on the next edge");

      // No acknowledge without a strobe one cycle before
      ack_needs_stb: assert property (
         @(posedge dsp_clk) disable iff (!rst_n_i) ack_i |-> $past(stb_i)
      ) else $error("readback acknowledge without a preceding strobe");
   end

   // Interrupt is a single-cycle pulse
   if (CHECK_PULSE) begin : g_pulse
      pulse_single: assert property (
         @(posedge dsp_clk) disable iff (!rst_n_i) pulse_i |=> !pulse_i
      ) else $error("PPS interrupt held high for two cycles");
   end

endmodule

bind readback_mux u2_control_core_assertions #(
   .CHECK_ACK   (1'b1),
   .CHECK_PULSE (1'b0)
) rb_checks (
   .dsp_clk (dsp_clk),
   .rst_n_i (rst_n_i),
   .stb_i   (rb_stb_i),
   .ack_i   (rb_ack_o),
   .pulse_i (1'b0)
);

bind vita_timekeeper u2_control_core_assertions #(
   .CHECK_ACK   (1'b0),
   .CHECK_PULSE (1'b1)
) pps_checks (
   .dsp_clk (dsp_clk),
   .rst_n_i (rst_n_i),
   .stb_i   (1'b0),
   .ack_i   (1'b0),
   .pulse_i (pps_int_o)
);

`default_nettype wire

//--- src/readback_mux.sv
/*
 * Registered readback of control, timing and constant words
 */
`default_nettype none

module readback_mux #(
   parameter logic [31:0] COMPAT_NUM = 32'd3
) (
   input  wire                      dsp_clk,
   input  wire                      rst_n_i,
   input  wire                      rb_stb_i,
   input  u2_ctrl_pkg::rb_word_e    rb_addr_i,
   input  u2_ctrl_pkg::ctrl_regs_t  regs_i,
   input  u2_ctrl_pkg::time_state_t time_i,
   input  wire                      sim_mode_i,
   input  wire  [3:0]               clock_divider_i,
   output logic [31:0]              rb_data_o,
   output logic                     rb_ack_o
);

   import u2_ctrl_pkg::*;

   logic [31:0] rb_word;

   // Word layout by index
   always_comb begin
      case (rb_addr_i)
         RB_CTRL: begin
            rb_word = {7'd0, regs_i.phy_reset, regs_i.adc_outs,
                       regs_i.serdes_outs, regs_i.clock_outs};
         end
         RB_LED:     rb_word = {16'd0, regs_i.led_src, regs_i.led_sw};
         RB_TIME_HI: rb_word = time_i.vita_time[63:32];
         RB_TIME_LO: rb_word = time_i.vita_time[31:0];
         RB_PPS_HI:  rb_word = time_i.vita_time_pps[63:32];
         RB_PPS_LO:  rb_word = time_i.vita_time_pps[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_SIM:     rb_word = {sim_mode_i, 27'd0, clock_divider_i};
         default:    rb_word = 32'd0;
      endcase
   end

   //////////////////////////////
   // Output register
   //////////////////////////////

   // Data holds until the next strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= rb_word;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

endmodule

`default_nettype wire

//--- src/setting_regs.sv
/*
 * Settings register bank for clock, SERDES, ADC and PHY control lines,
 * with the software/hardware LED mix
 */
`default_nettype none

module setting_regs (
   input  wire                     dsp_clk,
   input  wire                     rst_n_i,
   input  u2_ctrl_pkg::set_bus_t   set_i,
   input  wire  [7:0]              hw_led_i,
   output u2_ctrl_pkg::ctrl_regs_t regs_o,
   output logic [7:0]              leds_o
);

   import u2_ctrl_pkg::*;

   ctrl_regs_t regs_q;

   //////////////////////////////
   // Register writes
   //////////////////////////////

   // Only the low bits of the data word are kept
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         regs_q <= '{
            clock_outs:  8'd0,
            serdes_outs: 8'd0,
            adc_outs:    8'd0,
            led_sw:      8'd0,
            led_src:     LED_SRC_RESET,
            phy_reset:   1'b0
         };
      end else if (set_i.stb) begin
         case (set_i.addr)
            SR_CLOCK: begin
               regs_q.clock_outs <= set_i.data[7:0];
            end
            SR_SERDES: begin
               regs_q.serdes_outs <= set_i.data[7:0];
            end
            SR_ADC: begin
               regs_q.adc_outs <= set_i.data[7:0];
            end
            SR_LED_SW: begin
               regs_q.led_sw <= set_i.data[7:0];
            end
            SR_PHY: begin
               regs_q.phy_reset <= set_i.data[0];
            end
            SR_LED_SRC: begin
               regs_q.led_src <= set_i.data[7:0];
            end
            default: begin
               // Addresses owned by other blocks
            end
         endcase
      end
   end

   assign regs_o = regs_q;

   //////////////////////////////
   // LED mix
   //////////////////////////////

   // led_src bit set: hardware status drives the LED
   // led_src bit clear: software value drives it
   always_comb begin
      leds_o = (regs_q.led_src & hw_led_i) | (~regs_q.led_src & regs_q.led_sw);
   end

endmodule

`default_nettype wire

//--- src/u2_control_core.sv
/*
 * Control-plane core on dsp_clk: settings bank, VITA timekeeper and readback
 */
`default_nettype none

module u2_control_core #(
   parameter logic [7:0]  TIME_BASE  = u2_ctrl_pkg::SR_TIME64_DEFAULT,
   parameter logic [31:0] COMPAT_NUM = 32'd3
) (
   input  wire                    dsp_clk,
   input  wire                    rst_n_i,
   input  u2_ctrl_pkg::set_bus_t  set_i,
   input  wire                    pps_i,
   input  wire                    run_tx_i,
   input  wire                    run_rx_i,
   input  wire                    clk_status_i,
   input  wire                    serdes_link_up_i,
   input  wire                    rb_stb_i,
   input  u2_ctrl_pkg::rb_word_e  rb_addr_i,
   input  wire                    sim_mode_i,
   input  wire  [3:0]             clock_divider_i,
   output logic [7:0]             leds_o,
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,
   output logic                   ser_enable_o,
   output logic                   ser_prbsen_o,
   output logic                   ser_loopen_o,
   output logic                   ser_rx_en_o,
   output logic                   adc_oe_a_o,
   output logic                   adc_on_a_o,
   output logic                   adc_oe_b_o,
   output logic                   adc_on_b_o,
   output logic                   phy_resetn_o,
   output logic                   pps_int_o,
   output logic [31:0]            rb_data_o,
   output logic                   rb_ack_o
);

   import u2_ctrl_pkg::*;

   ctrl_regs_t  regs;
   time_state_t time_state;
   logic [7:0]  hw_led;

   // Hardware status for LEDs 4..1, LED 0 has no hardware source
   assign hw_led = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};

   //////////////////////////////
   // Blocks
   //////////////////////////////

   setting_regs setting_regs_i (
      .dsp_clk  (dsp_clk),
      .rst_n_i  (rst_n_i),
      .set_i    (set_i),
      .hw_led_i (hw_led),
      .regs_o   (regs),
      .leds_o   (leds_o)
   );

   vita_timekeeper #(
      .TIME_BASE (TIME_BASE)
   ) vita_timekeeper_i (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .set_i     (set_i),
      .pps_i     (pps_i),
      .time_o    (time_state),
      .pps_int_o (pps_int_o)
   );

   readback_mux #(
      .COMPAT_NUM (COMPAT_NUM)
   ) readback_mux_i (
      .dsp_clk         (dsp_clk),
      .rst_n_i         (rst_n_i),
      .rb_stb_i        (rb_stb_i),
      .rb_addr_i       (rb_addr_i),
      .regs_i          (regs),
      .time_i          (time_state),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .rb_data_o       (rb_data_o),
      .rb_ack_o        (rb_ack_o)
   );

   //////////////////////////////
   // Board control pins
   //////////////////////////////

   assign {clock_ready_o, clk_en_o, clk_sel_o} = regs.clock_outs[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = regs.serdes_outs[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = regs.adc_outs[3:0];

   // PHY reset pin is active low
   assign phy_resetn_o = ~regs.phy_reset;

endmodule

`default_nettype wire

//--- src/u2_ctrl_pkg.sv
/*
 * Control-plane definitions shared by the settings bank, the VITA timekeeper
 * and the readback mux
 */
`default_nettype none

package u2_ctrl_pkg;

   //////////////////////////////
   // Settings bus
   //////////////////////////////

   // One write on the settings bus, no handshake
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Register bank contents
   typedef struct packed {
      logic [7:0] clock_outs;
      logic [7:0] serdes_outs;
      logic [7:0] adc_outs;
      logic [7:0] led_sw;
      logic [7:0] led_src;
      logic       phy_reset;
   } ctrl_regs_t;

   // Running time and time latched at the last PPS
   typedef struct packed {
      logic [63:0] vita_time;
      logic [63:0] vita_time_pps;
   } time_state_t;

   //////////////////////////////
   // Settings addresses
   //////////////////////////////

   localparam logic [7:0] SR_CLOCK          = 8'd0;
   localparam logic [7:0] SR_SERDES         = 8'd1;
   localparam logic [7:0] SR_ADC            = 8'd2;
   localparam logic [7:0] SR_LED_SW         = 8'd3;
   localparam logic [7:0] SR_PHY            = 8'd4;
   localparam logic [7:0] SR_LED_SRC        = 8'd8;
   // Timekeeper uses three words from here
   localparam logic [7:0] SR_TIME64_DEFAULT = 8'd192;

   // LEDs 4..1 follow hardware status after reset
   localparam logic [7:0] LED_SRC_RESET     = 8'h1E;

   //////////////////////////////
   // Readback and load state
   //////////////////////////////

   typedef enum logic [2:0] {
      RB_CTRL,
      RB_LED,
      RB_TIME_HI,
      RB_TIME_LO,
      RB_PPS_HI,
      RB_PPS_LO,
      RB_COMPAT,
      RB_SIM
   } rb_word_e;

   typedef enum logic [1:0] {
      LOAD_IDLE,
      LOAD_WAIT_PPS
   } load_state_e;

endpackage

`default_nettype wire

//--- src/vita_timekeeper.sv
/*
 * VITA 64-bit time counter with PPS synchronizer, PPS time capture
 * and immediate or PPS-aligned time load
 */
`default_nettype none

module vita_timekeeper #(
   parameter logic [7:0] TIME_BASE = u2_ctrl_pkg::SR_TIME64_DEFAULT
) (
   input  wire                      dsp_clk,
   input  wire                      rst_n_i,
   input  u2_ctrl_pkg::set_bus_t    set_i,
   input  wire                      pps_i,
   output u2_ctrl_pkg::time_state_t time_o,
   output logic                     pps_int_o
);

   import u2_ctrl_pkg::*;

   localparam logic [7:0] ADDR_HI   = TIME_BASE;
   localparam logic [7:0] ADDR_LO   = TIME_BASE + 8'd1;
   localparam logic [7:0] ADDR_CTRL = TIME_BASE + 8'd2;

   logic        pps_sync1_q;
   logic        pps_sync2_q;
   logic        pps_last_q;
   logic        pps_edge_q;
   logic [31:0] time_hi_q;
   logic [31:0] time_lo_q;
   logic [63:0] vita_time_q;
   logic [63:0] vita_time_pps_q;
   load_state_e load_state_q;
   logic        ctrl_wr;
   logic        pps_load;

   //////////////////////////////
   // PPS input
   //////////////////////////////

   // Two-flop synchronizer, then a registered rising edge
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pps_sync1_q <= 1'b0;
         pps_sync2_q <= 1'b0;
         pps_last_q  <= 1'b0;
         pps_edge_q  <= 1'b0;
         pps_int_o   <= 1'b0;
      end else begin
         pps_sync1_q <= pps_i;
         pps_sync2_q <= pps_sync1_q;
         pps_last_q  <= pps_sync2_q;
         pps_edge_q  <= pps_sync2_q & ~pps_last_q;
         pps_int_o   <= pps_edge_q;
      end
   end

   //////////////////////////////
   // Pending load words
   //////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && (set_i.addr == ADDR_HI)) begin
         time_hi_q <= set_i.data;
      end
      if (set_i.stb && (set_i.addr == ADDR_LO)) begin
         time_lo_q <= set_i.data;
      end
   end

   assign ctrl_wr  = set_i.stb && (set_i.addr == ADDR_CTRL);
   assign pps_load = pps_edge_q && (load_state_q == LOAD_WAIT_PPS);

   //////////////////////////////
   // Counter and load FSM
   //////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         vita_time_q     <= 64'd0;
         vita_time_pps_q <= 64'd0;
         load_state_q    <= LOAD_IDLE;
      end else begin
         // Bit 0 set means load now, clear means wait for PPS
         if ((ctrl_wr && set_i.data[0]) || pps_load) begin
            vita_time_q <= {time_hi_q, time_lo_q};
         end else begin
            vita_time_q <= vita_time_q + 64'd1;
         end

         if (ctrl_wr) begin
            load_state_q <= set_i.data[0] ? LOAD_IDLE : LOAD_WAIT_PPS;
         end else if (pps_load) begin
            load_state_q <= LOAD_IDLE;
         end

         if (pps_edge_q) begin
            vita_time_pps_q <= vita_time_q;
         end
      end
   end

   assign time_o.vita_time     = vita_time_q;
   assign time_o.vita_time_pps = vita_time_pps_q;

endmodule

`default_nettype wire

//--- u2_control_core.f
src/u2_ctrl_pkg.sv
src/setting_regs.sv
src/vita_timekeeper.sv
src/readback_mux.sv
src/u2_control_core.sv
sim/u2_control_core_assertions.sv
sim/tb_u2_control_core.sv
